// File: logic/lsu_pkg.sv
`default_nettype none

package lsu_pkg;

    // ----------------------------------------------------------------------
    // word geometry
    // ----------------------------------------------------------------------

    localparam int data_w = 32;

    // one byte per lane, little endian
    localparam int lanes = data_w / 8;

    // idle value on data outputs
    localparam logic [data_w-1:0] zero_word = '0;

    // ----------------------------------------------------------------------
    // access width of a load or store
    // ----------------------------------------------------------------------

    // 2'b11 is left free and decodes as no access
    typedef enum logic [1:0] {
        size_byte = 2'b00,
        size_half = 2'b01,
        size_word = 2'b10
    } access_size_t;

endpackage

`default_nettype wire

// File: logic/store_align.sv
`timescale 1ns/1ps
`default_nettype none

module store_align (
    input  wire [1:0]                  addr,        // byte offset within the word
    input  wire [lsu_pkg::data_w-1:0]  wdata,
    input  wire lsu_pkg::access_size_t size,
    input  wire                        wr,
    output logic [lsu_pkg::lanes-1:0]  lane_we,
    output logic [lsu_pkg::data_w-1:0] lane_wdata
);

    logic [lsu_pkg::lanes-1:0]  we_pattern;
    logic [lsu_pkg::data_w-1:0] data_placed;

    // ----------------------------------------------------------------------
    // size and offset decode
    // ----------------------------------------------------------------------

    always_comb
    begin
        we_pattern  = '0;
        data_placed = lsu_pkg::zero_word;
        case (size)
            lsu_pkg::size_byte:
            begin
                case (addr)
                    2'd0:
                    begin
                        we_pattern  = 4'b0001;
                        data_placed = {24'b0, wdata[7:0]};
                    end
                    2'd1:
                    begin
                        we_pattern  = 4'b0010;
                        data_placed = {16'b0, wdata[7:0], 8'b0};
                    end
                    2'd2:
                    begin
                        we_pattern  = 4'b0100;
                        data_placed = {8'b0, wdata[7:0], 16'b0};
                    end
                    default:
                    begin
                        we_pattern  = 4'b1000;
                        data_placed = {wdata[7:0], 24'b0};
                    end
                endcase
            end
            lsu_pkg::size_half:
            begin
                // addr[0] ignored, no misalign check
                if (addr[1])
                begin
                    we_pattern  = 4'b1100;
                    data_placed = {wdata[15:0], 16'b0};
                end
                else
                begin
                    we_pattern  = 4'b0011;
                    data_placed = {16'b0, wdata[15:0]};
                end
            end
            lsu_pkg::size_word:
            begin
                we_pattern  = 4'b1111;
                data_placed = wdata;
            end
            default:
            begin
                we_pattern  = '0;              // unused code, nothing written
                data_placed = lsu_pkg::zero_word;
            end
        endcase
    end

    // enables only live while the store strobe is up
    assign lane_we    = wr ? we_pattern : '0;
    assign lane_wdata = wr ? data_placed : lsu_pkg::zero_word;

endmodule

`default_nettype wire

// File: logic/byte_bank.sv
`timescale 1ns/1ps
`default_nettype none

module byte_bank #(
    parameter int DEPTH = 256
) (
    input  wire                     clk,
    input  wire [$clog2(DEPTH)-1:0] word_addr,
    input  wire                     we,
    input  wire [7:0]               wbyte,
    input  wire                     rd,
    output logic [7:0]              rbyte
);

    logic [7:0] mem [DEPTH];

    // ----------------------------------------------------------------------
    // write port
    // ----------------------------------------------------------------------

    always_ff @(posedge clk)
    begin
        if (we)
        begin
            mem[word_addr] <= wbyte;
        end
    end

    // ----------------------------------------------------------------------
    // read port
    // ----------------------------------------------------------------------

    // same-edge write lands after this sample, so a hit returns old data
    always_ff @(posedge clk)
    begin
        if (rd)
        begin
            rbyte <= mem[word_addr];   // held until the next read
        end
    end

endmodule

`default_nettype wire

// File: logic/load_extract.sv
`timescale 1ns/1ps
`default_nettype none

module load_extract (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire [1:0]                  offset,
    input  wire lsu_pkg::access_size_t size,
    input  wire                        unsigned_ld,
    input  wire [lsu_pkg::data_w-1:0]  lane_rdata,
    output logic [lsu_pkg::data_w-1:0] rdata
);

    lsu_pkg::access_size_t size_q;
    logic [1:0]            offset_q;
    logic                  unsigned_q;

    logic [7:0]  sel_byte;
    logic [15:0] sel_half;
    logic        fill_byte;
    logic        fill_half;

    // ----------------------------------------------------------------------
    // access attributes, aligned with the bank read data
    // ----------------------------------------------------------------------

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            size_q     <= lsu_pkg::size_byte;
            offset_q   <= 2'd0;
            unsigned_q <= 1'b0;
        end
        else
        begin
            size_q     <= size;          // captured every edge
            offset_q   <= offset;
            unsigned_q <= unsigned_ld;
        end
    end

    // ----------------------------------------------------------------------
    // lane select
    // ----------------------------------------------------------------------

    always_comb
    begin
        case (offset_q)
            2'd0:    sel_byte = lane_rdata[7:0];
            2'd1:    sel_byte = lane_rdata[15:8];
            2'd2:    sel_byte = lane_rdata[23:16];
            default: sel_byte = lane_rdata[31:24];
        endcase
    end

    assign sel_half = offset_q[1] ? lane_rdata[31:16] : lane_rdata[15:0];

    // sign bit unless unsigned load
    assign fill_byte = sel_byte[7] & ~unsigned_q;
    assign fill_half = sel_half[15] & ~unsigned_q;

    // ----------------------------------------------------------------------
    // extension
    // ----------------------------------------------------------------------

    always_comb
    begin
        case (size_q)
            lsu_pkg::size_byte:
                rdata = {{24{fill_byte}}, sel_byte};
            lsu_pkg::size_half:
                rdata = {{16{fill_half}}, sel_half};
            lsu_pkg::size_word:
                rdata = lane_rdata;
            default:
                rdata = lsu_pkg::zero_word;
        endcase
    end

endmodule

`default_nettype wire

// File: logic/data_mem_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

module data_mem_subsystem #(
    parameter int DEPTH = 256   // words, power of two
) (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire [31:0]                 addr,
    input  wire [lsu_pkg::data_w-1:0]  wdata,
    input  wire lsu_pkg::access_size_t size,
    input  wire                        unsigned_ld,
    input  wire                        rd,
    input  wire                        wr,
    output logic [lsu_pkg::data_w-1:0] rdata
);

    localparam int addr_w = $clog2(DEPTH);

    logic [lsu_pkg::lanes-1:0]  lane_we;
    logic [lsu_pkg::data_w-1:0] lane_wdata;
    logic [lsu_pkg::data_w-1:0] lane_rdata;
    logic [addr_w-1:0]          word_addr;

    // upper address bits above the array are ignored
    assign word_addr = addr[addr_w+1:2];

    // ----------------------------------------------------------------------
    // store path
    // ----------------------------------------------------------------------

    store_align u_store_align (
        .addr       (addr[1:0]),
        .wdata      (wdata),
        .size       (size),
        .wr         (wr),
        .lane_we    (lane_we),
        .lane_wdata (lane_wdata)
    );

    // ----------------------------------------------------------------------
    // byte banks, lane i holds bits 8*i+7 : 8*i
    // ----------------------------------------------------------------------

    for (genvar i = 0; i < lsu_pkg::lanes; i++)
    begin : g_bank
        byte_bank #(
            .DEPTH (DEPTH)
        ) u_bank (
            .clk       (clk),
            .word_addr (word_addr),
            .we        (lane_we[i]),
            .wbyte     (lane_wdata[8*i +: 8]),
            .rd        (rd),
            .rbyte     (lane_rdata[8*i +: 8])
        );
    end

    // ----------------------------------------------------------------------
    // load path
    // ----------------------------------------------------------------------

    load_extract u_load_extract (
        .clk         (clk),
        .rst_n       (rst_n),
        .offset      (addr[1:0]),
        .size        (size),
        .unsigned_ld (unsigned_ld),
        .lane_rdata  (lane_rdata),
        .rdata       (rdata)        // valid the cycle after rd
    );

endmodule

`default_nettype wire

// File: tests/data_mem_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module data_mem_assertions (
    input wire                        clk,
    input wire                        rst_n,
    input wire                        rd,
    input wire                        wr,
    input wire lsu_pkg::access_size_t size,
    input wire                        unsigned_ld,
    input wire [lsu_pkg::lanes-1:0]   lane_we,
    input wire [lsu_pkg::data_w-1:0]  rdata
);

    // ----------------------------------------------------------------------
    // store enables
    // ----------------------------------------------------------------------

    no_we_without_wr : assert property (
        @(posedge clk) disable iff (!rst_n) !wr |-> (lane_we == '0)
    ) else $error("lane enables active while no store is requested");

    byte_store_one_lane : assert property (
        @(posedge clk) disable iff (!rst_n)
        (wr && size == lsu_pkg::size_byte) |-> $onehot(lane_we)
    ) else $error("byte store enabled other than exactly one lane");

    // halfword lanes come as a pair
    half_store_pair : assert property (
        @(posedge clk) disable iff (!rst_n)
        (wr && size == lsu_pkg::size_half) |-> (lane_we == 4'b0011 || lane_we == 4'b1100)
    ) else $error("halfword store enabled a lane pattern that is not a pair");

    // ----------------------------------------------------------------------
    // unsigned byte load
    // ----------------------------------------------------------------------

    ubyte_upper_zero : assert property (
        @(posedge clk) disable iff (!rst_n)
        ($past(rd) && $past(unsigned_ld) && $past(size) == lsu_pkg::size_byte)
        |-> (rdata[31:8] == 24'b0)
    ) else $error("unsigned byte load returned nonzero upper bits");

endmodule

bind data_mem_subsystem data_mem_assertions u_assertions (
    .clk         (clk),
    .rst_n       (rst_n),
    .rd          (rd),
    .wr          (wr),
    .size        (size),
    .unsigned_ld (unsigned_ld),
    .lane_we     (lane_we),
    .rdata       (rdata)
);

`default_nettype wire

// File: tests/data_mem_tb.sv
`timescale 1ns/1ps
`default_nettype none

module data_mem_tb;

    localparam int depth   = 256;
    localparam int addr_w  = $clog2(depth);
    localparam int n_words = 8;

    // cycles per test at one drive step each
    localparam int reset_cycles  = 5;
    localparam int word_cycles   = 2 * n_words + 1;
    localparam int merge_cycles  = 10;
    localparam int half_cycles   = 6;
    localparam int ext_cycles    = 27;
    localparam int rbw_cycles    = 4;
    localparam int b2b_cycles    = n_words + 1;
    localparam int timeout_limit = reset_cycles + word_cycles + merge_cycles + half_cycles
                                   + ext_cycles + rbw_cycles + b2b_cycles + 100;

    logic                         clk;
    logic                         rst_n;
    logic [31:0]                  addr;
    logic [lsu_pkg::data_w-1:0]   wdata;
    lsu_pkg::access_size_t        size;
    logic                         unsigned_ld;
    logic                         rd;
    logic                         wr;
    logic [lsu_pkg::data_w-1:0]   rdata;

    logic [7:0]  ref_mem [depth*4];     // byte-addressed model
    logic [31:0] word_addrs [n_words];

    logic        pend_valid;
    logic [31:0] pend_exp;
    string       pend_name;

    int          cycle_count;
    int          check_count;
    int          rdata_errors;
    int          lane_errors;

    data_mem_subsystem #(
        .DEPTH (depth)
    ) DUT (
        .clk         (clk),
        .rst_n       (rst_n),
        .addr        (addr),
        .wdata       (wdata),
        .size        (size),
        .unsigned_ld (unsigned_ld),
        .rd          (rd),
        .wr          (wr),
        .rdata       (rdata)
    );

    always #2 clk = ~clk;

    always @(posedge clk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_limit)
        begin
            $display("run stopped after %0d cycles without finishing the tests", cycle_count);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    // ----------------------------------------------------------------------
    // reference model
    // ----------------------------------------------------------------------

    task automatic model_store(input lsu_pkg::access_size_t sz, input logic [31:0] a,
                               input logic [31:0] d);
        logic [addr_w-1:0] w_idx;
        w_idx = a[addr_w+1:2];
        case (sz)
            lsu_pkg::size_byte:
                ref_mem[{w_idx, a[1:0]}] = d[7:0];
            lsu_pkg::size_half:
            begin
                ref_mem[{w_idx, a[1], 1'b0}] = d[7:0];
                ref_mem[{w_idx, a[1], 1'b1}] = d[15:8];
            end
            lsu_pkg::size_word:
            begin
                ref_mem[{w_idx, 2'd0}] = d[7:0];
                ref_mem[{w_idx, 2'd1}] = d[15:8];
                ref_mem[{w_idx, 2'd2}] = d[23:16];
                ref_mem[{w_idx, 2'd3}] = d[31:24];
            end
            default:
                ;                       // no access
        endcase
    endtask

    function automatic logic [31:0] expected_load(input lsu_pkg::access_size_t sz,
                                                  input logic uns, input logic [31:0] a);
        logic [addr_w-1:0] w_idx;
        logic [7:0]        b;
        logic [15:0]       h;
        logic [31:0]       result;
        w_idx = a[addr_w+1:2];
        result = 32'b0;
        case (sz)
            lsu_pkg::size_byte:
            begin
                b = ref_mem[{w_idx, a[1:0]}];
                result = uns ? {24'b0, b} : {{24{b[7]}}, b};
            end
            lsu_pkg::size_half:
            begin
                h = {ref_mem[{w_idx, a[1], 1'b1}], ref_mem[{w_idx, a[1], 1'b0}]};
                result = uns ? {16'b0, h} : {{16{h[15]}}, h};
            end
            lsu_pkg::size_word:
                result = {ref_mem[{w_idx, 2'd3}], ref_mem[{w_idx, 2'd2}],
                          ref_mem[{w_idx, 2'd1}], ref_mem[{w_idx, 2'd0}]};
            default:
                result = 32'b0;
        endcase
        return result;
    endfunction

    // ----------------------------------------------------------------------
    // compare tasks
    // ----------------------------------------------------------------------

    task automatic check_word(input string name, input logic [lsu_pkg::data_w-1:0] exp,
                              input logic [lsu_pkg::data_w-1:0] got);
        check_count++;
        if (got !== exp)
        begin
            rdata_errors++;
            $display("Mismatch at %0t: %s expected %h got %h", $time, name, exp, got);
        end
    endtask

    task automatic check_lanes(input lsu_pkg::access_size_t sz, input logic [1:0] off,
                               input logic [lsu_pkg::lanes-1:0] got);
        logic [lsu_pkg::lanes-1:0] exp;
        case (sz)
            lsu_pkg::size_byte: exp = 4'b0001 << off;
            lsu_pkg::size_half: exp = off[1] ? 4'b1100 : 4'b0011;
            lsu_pkg::size_word: exp = 4'b1111;
            default:            exp = 4'b0000;
        endcase
        check_count++;
        if (got !== exp)
        begin
            lane_errors++;
            $display("Mismatch at %0t: lane_we (%s, offset %0d) expected %b got %b",
                     $time, sz.name(), off, exp, got);
        end
    endtask

    // ----------------------------------------------------------------------
    // one request per cycle with its result checked on the next
    // ----------------------------------------------------------------------

    task automatic drive_access(input logic r, input logic w, input lsu_pkg::access_size_t sz,
                                input logic uns, input logic [31:0] a, input logic [31:0] d,
                                input string name);
        @(posedge clk);
        #0.5;
        if (pend_valid)
        begin
            check_word(pend_name, pend_exp, rdata);
        end
        pend_valid = r;
        if (r)
        begin
            pend_exp  = expected_load(sz, uns, a);  // old contents on a same-word write
            pend_name = name;
        end
        if (w)
        begin
            model_store(sz, a, d);
        end
        rd          = r;
        wr          = w;
        size        = sz;
        unsigned_ld = uns;
        addr        = a;
        wdata       = d;
        if (w)
        begin
            #1;
            check_lanes(sz, a[1:0], DUT.lane_we);
        end
    endtask

    task automatic idle_cycle();
        drive_access(1'b0, 1'b0, lsu_pkg::size_byte, 1'b0, 32'h0, 32'h0, "idle");
    endtask

    // ----------------------------------------------------------------------
    // directed tests
    // ----------------------------------------------------------------------

    task automatic test_word_roundtrip();
        for (int i = 0; i < n_words; i++)
        begin
            word_addrs[i] = 32'($urandom % depth) << 2;
            drive_access(1'b0, 1'b1, lsu_pkg::size_word, 1'b0, word_addrs[i], $urandom, "wr");
        end
        for (int i = 0; i < n_words; i++)
        begin
            drive_access(1'b1, 1'b0, lsu_pkg::size_word, 1'b0, word_addrs[i], 32'h0,
                         "rdata (word round-trip)");
        end
        idle_cycle();
    endtask

    task automatic test_byte_merge();
        drive_access(1'b0, 1'b1, lsu_pkg::size_word, 1'b0, 32'h40, 32'h1122_3344, "wr");
        for (int off = 0; off < 4; off++)
        begin
            drive_access(1'b0, 1'b1, lsu_pkg::size_byte, 1'b0, 32'h40 + off, $urandom, "wr");
            drive_access(1'b1, 1'b0, lsu_pkg::size_word, 1'b0, 32'h40, 32'h0,
                         "rdata (byte merge)");
        end
        idle_cycle();
    endtask

    task automatic test_half_placement();
        drive_access(1'b0, 1'b1, lsu_pkg::size_word, 1'b0, 32'h80, 32'ha5a5_5a5a, "wr");
        drive_access(1'b0, 1'b1, lsu_pkg::size_half, 1'b0, 32'h80, 32'h0000_beef, "wr");
        drive_access(1'b1, 1'b0, lsu_pkg::size_word, 1'b0, 32'h80, 32'h0, "rdata (half low)");
        drive_access(1'b0, 1'b1, lsu_pkg::size_half, 1'b0, 32'h82, 32'h0000_1234, "wr");
        drive_access(1'b1, 1'b0, lsu_pkg::size_word, 1'b0, 32'h80, 32'h0, "rdata (half high)");
        idle_cycle();
    endtask

    task automatic test_load_extension();
        logic [31:0] a;
        // every lane has its top bit clear at 0x100 and set at 0x104
        drive_access(1'b0, 1'b1, lsu_pkg::size_word, 1'b0, 32'h100, $urandom & 32'h7f7f_7f7f,
                     "wr");
        drive_access(1'b0, 1'b1, lsu_pkg::size_word, 1'b0, 32'h104, $urandom | 32'h8080_8080,
                     "wr");
        for (int w = 0; w < 2; w++)
        begin
            for (int off = 0; off < 4; off++)
            begin
                a = 32'h100 + 32'(4 * w + off);
                drive_access(1'b1, 1'b0, lsu_pkg::size_byte, 1'b0, a, 32'h0, "rdata (lb)");
                drive_access(1'b1, 1'b0, lsu_pkg::size_byte, 1'b1, a, 32'h0, "rdata (lbu)");
            end
            for (int off = 0; off < 4; off += 2)
            begin
                a = 32'h100 + 32'(4 * w + off);
                drive_access(1'b1, 1'b0, lsu_pkg::size_half, 1'b0, a, 32'h0, "rdata (lh)");
                drive_access(1'b1, 1'b0, lsu_pkg::size_half, 1'b1, a, 32'h0, "rdata (lhu)");
            end
        end
        idle_cycle();
    endtask

    task automatic test_read_before_write();
        drive_access(1'b0, 1'b1, lsu_pkg::size_word, 1'b0, 32'hc0, 32'hcafe_0001, "wr");
        drive_access(1'b1, 1'b1, lsu_pkg::size_word, 1'b0, 32'hc0, 32'hdead_0002,
                     "rdata (same-cycle read, old value)");
        drive_access(1'b1, 1'b0, lsu_pkg::size_word, 1'b0, 32'hc0, 32'h0,
                     "rdata (read after write, new value)");
        idle_cycle();
    endtask

    task automatic test_back_to_back();
        lsu_pkg::access_size_t sz;
        logic [31:0]           a;
        for (int i = 0; i < n_words; i++)
        begin
            sz = lsu_pkg::access_size_t'(2'($urandom % 3));
            a  = word_addrs[i] | 32'($urandom % 4);
            drive_access(1'b1, 1'b0, sz, 1'($urandom % 2), a, 32'h0, "rdata (back-to-back)");
        end
        idle_cycle();
    endtask

    // ----------------------------------------------------------------------
    // main sequence
    // ----------------------------------------------------------------------

    initial
    begin
        clk          = 1'b0;
        rst_n        = 1'b0;
        addr         = 32'h0;
        wdata        = 32'h0;
        size         = lsu_pkg::size_byte;
        unsigned_ld  = 1'b0;
        rd           = 1'b0;
        wr           = 1'b0;
        pend_valid   = 1'b0;
        pend_exp     = 32'h0;
        pend_name    = "";
        cycle_count  = 0;
        check_count  = 0;
        rdata_errors = 0;
        lane_errors  = 0;
        void'($urandom(20));

        repeat (reset_cycles) @(posedge clk);
        #0.5;
        rst_n = 1'b1;

        test_word_roundtrip();
        test_byte_merge();
        test_half_placement();
        test_load_extension();
        test_read_before_write();
        test_back_to_back();

        $display("checks %0d, rdata mismatches %0d, lane_we mismatches %0d",
                 check_count, rdata_errors, lane_errors);
        if (rdata_errors == 0 && lane_errors == 0)
        begin
            $display("RESULT: PASS");
        end
        else
        begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
logic/lsu_pkg.sv
logic/store_align.sv
logic/byte_bank.sv
logic/load_extract.sv
logic/data_mem_subsystem.sv
tests/data_mem_assertions.sv
tests/data_mem_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = data_mem_tb
FILELIST  = vlog.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: sim clean

# the log decides pass or fail
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then exit 1; fi
	@grep -q "RESULT: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
